/* rtl/rv32i_pkg.sv */
package rv32i_pkg;

  typedef logic [31:0] xlen_t;     // architectural word
  typedef logic [15:0] half_t;     // one memory bus beat
  typedef logic [4:0]  reg_addr_t;

  typedef logic [3:0] inst_class_t;

  localparam inst_class_t CLASS_LUI     = 4'd0;
  localparam inst_class_t CLASS_AUIPC   = 4'd1;
  localparam inst_class_t CLASS_JAL     = 4'd2;
  localparam inst_class_t CLASS_JALR    = 4'd3;
  localparam inst_class_t CLASS_BRANCH  = 4'd4;
  localparam inst_class_t CLASS_LOAD    = 4'd5;
  localparam inst_class_t CLASS_STORE   = 4'd6;
  localparam inst_class_t CLASS_OPIMM   = 4'd7;
  localparam inst_class_t CLASS_OP      = 4'd8;
  localparam inst_class_t CLASS_ILLEGAL = 4'd15;

  // sequencer steps, one instruction in flight at a time
  typedef enum logic [2:0] {
    FETCH_LO,
    FETCH_HI,
    EXEC,
    MEM_LO,
    MEM_HI,
    WRITEBACK,
    HALTED
  } seq_state_t;

  typedef logic [1:0] alu_mode_t;

  localparam alu_mode_t ALU_ADD       = 2'd0;  // addresses and targets
  localparam alu_mode_t ALU_FUNCT_IMM = 2'd1;  // bit 30 only for shifts
  localparam alu_mode_t ALU_FUNCT_REG = 2'd2;  // bit 30 picks SUB / SRA

  typedef logic [1:0] wb_sel_t;

  localparam wb_sel_t WB_ALU  = 2'd0;
  localparam wb_sel_t WB_LOAD = 2'd1;
  localparam wb_sel_t WB_LINK = 2'd2;  // pc + 4
  localparam wb_sel_t WB_IMM  = 2'd3;  // lui

endpackage

/* rtl/rv32i_decode.sv */
`timescale 1ns/1ns

module rv32i_decode (
  input  logic                   clk_i,
  input  logic                   microcode_reset,
  input  logic                   load_lo_i,
  input  logic                   load_hi_i,
  input  rv32i_pkg::half_t       fetch_half_i,
  output rv32i_pkg::inst_class_t inst_class_o,
  output rv32i_pkg::reg_addr_t   rs1_addr_o,
  output rv32i_pkg::reg_addr_t   rs2_addr_o,
  output rv32i_pkg::reg_addr_t   rd_addr_o,
  output logic [2:0]             funct3_o,
  output logic                   funct7_b5_o,
  output rv32i_pkg::xlen_t       imm_o
);
  import rv32i_pkg::*;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  xlen_t      inst_q;
  logic [6:0] opcode;
  logic [6:0] funct7;

  always_ff @(posedge clk_i) begin
    if (!microcode_reset) begin
      inst_q <= '0;
    end else begin
      if (load_lo_i) inst_q[15:0] <= fetch_half_i;
      if (load_hi_i) inst_q[31:16] <= fetch_half_i;
    end
  end

  assign opcode      = inst_q[6:0];
  assign funct7      = inst_q[31:25];
  assign rd_addr_o   = inst_q[11:7];
  assign rs1_addr_o  = inst_q[19:15];
  assign rs2_addr_o  = inst_q[24:20];
  assign funct3_o    = inst_q[14:12];
  assign funct7_b5_o = inst_q[30];

  always_comb begin
    case (opcode)
      OPC_LUI, OPC_AUIPC:
        imm_o = {inst_q[31:12], 12'b0};
      OPC_JAL:
        imm_o = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
      OPC_BRANCH:
        imm_o = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
      OPC_STORE:
        imm_o = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
      default:
        imm_o = {{20{inst_q[31]}}, inst_q[31:20]};  // I type
    endcase
  end

  // only the word-sized subset and the base integer ops are accepted
  always_comb begin
    inst_class_o = CLASS_ILLEGAL;
    case (opcode)
      OPC_LUI:   inst_class_o = CLASS_LUI;
      OPC_AUIPC: inst_class_o = CLASS_AUIPC;
      OPC_JAL:   inst_class_o = CLASS_JAL;
      OPC_JALR:
        if (funct3_o == 3'b000) inst_class_o = CLASS_JALR;
      OPC_BRANCH:
        if (funct3_o[2:1] != 2'b01) inst_class_o = CLASS_BRANCH;
      OPC_LOAD:
        if (funct3_o == 3'b010) inst_class_o = CLASS_LOAD;
      OPC_STORE:
        if (funct3_o == 3'b010) inst_class_o = CLASS_STORE;
      OPC_OPIMM: begin
        if (funct3_o == 3'b001) begin
          if (funct7 == 7'b0000000) inst_class_o = CLASS_OPIMM;
        end else if (funct3_o == 3'b101) begin
          if (funct7 == 7'b0000000 || funct7 == 7'b0100000) inst_class_o = CLASS_OPIMM;
        end else begin
          inst_class_o = CLASS_OPIMM;
        end
      end
      OPC_OP: begin
        if (funct7 == 7'b0000000) inst_class_o = CLASS_OP;
        else if (funct7 == 7'b0100000 && (funct3_o == 3'b000 || funct3_o == 3'b101))
          inst_class_o = CLASS_OP;  // sub, sra
      end
      default: inst_class_o = CLASS_ILLEGAL;  // ecall, ebreak, fence and the rest
    endcase
  end

endmodule

/* rtl/rv32i_execute.sv */
`timescale 1ns/1ns

module rv32i_execute (
  input  rv32i_pkg::xlen_t     pc_i,
  input  rv32i_pkg::xlen_t     rs1_data_i,
  input  rv32i_pkg::xlen_t     rs2_data_i,
  input  rv32i_pkg::xlen_t     imm_i,
  input  logic                 op_a_pc_i,
  input  logic                 op_b_imm_i,
  input  rv32i_pkg::alu_mode_t alu_mode_i,
  input  logic [2:0]           funct3_i,
  input  logic                 funct7_b5_i,
  output rv32i_pkg::xlen_t     alu_result_o,
  output logic                 branch_taken_o
);
  import rv32i_pkg::*;

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  logic       use_funct;
  logic       alt_op;  // sub or sra

  assign op_a      = op_a_pc_i ? pc_i : rs1_data_i;
  assign op_b      = op_b_imm_i ? imm_i : rs2_data_i;
  assign shamt     = op_b[4:0];
  assign use_funct = (alu_mode_i == ALU_FUNCT_IMM) || (alu_mode_i == ALU_FUNCT_REG);

  always_comb begin
    alt_op = 1'b0;
    if (alu_mode_i == ALU_FUNCT_REG) alt_op = funct7_b5_i;
    else if (alu_mode_i == ALU_FUNCT_IMM && funct3_i == 3'b101) alt_op = funct7_b5_i;
  end

  always_comb begin
    alu_result_o = op_a + op_b;
    if (use_funct) begin
      case (funct3_i)
        3'b000:  alu_result_o = alt_op ? op_a - op_b : op_a + op_b;
        3'b001:  alu_result_o = op_a << shamt;
        3'b010:  alu_result_o = {31'b0, $signed(op_a) < $signed(op_b)};
        3'b011:  alu_result_o = {31'b0, op_a < op_b};
        3'b100:  alu_result_o = op_a ^ op_b;
        3'b101:  alu_result_o = alt_op ? xlen_t'($signed(op_a) >>> shamt) : op_a >> shamt;
        3'b110:  alu_result_o = op_a | op_b;
        default: alu_result_o = op_a & op_b;
      endcase
    end
  end

  // branch compare always on the register pair
  always_comb begin
    case (funct3_i)
      3'b000:  branch_taken_o = (rs1_data_i == rs2_data_i);
      3'b001:  branch_taken_o = (rs1_data_i != rs2_data_i);
      3'b100:  branch_taken_o = ($signed(rs1_data_i) < $signed(rs2_data_i));
      3'b101:  branch_taken_o = ($signed(rs1_data_i) >= $signed(rs2_data_i));
      3'b110:  branch_taken_o = (rs1_data_i < rs2_data_i);
      3'b111:  branch_taken_o = (rs1_data_i >= rs2_data_i);
      default: branch_taken_o = 1'b0;
    endcase
  end

endmodule

/* rtl/rv32i_result.sv */
`timescale 1ns/1ns

module rv32i_result #(
  parameter int NUM_REGS = 32
) (
  input  logic                 clk_i,
  input  logic                 microcode_reset,
  input  rv32i_pkg::reg_addr_t rs1_addr_i,
  input  rv32i_pkg::reg_addr_t rs2_addr_i,
  input  rv32i_pkg::reg_addr_t rd_addr_i,
  input  logic                 reg_write_i,
  input  rv32i_pkg::wb_sel_t   wb_sel_i,
  input  rv32i_pkg::xlen_t     alu_result_i,
  input  rv32i_pkg::xlen_t     imm_i,
  input  rv32i_pkg::xlen_t     pc_i,
  input  logic                 load_lo_i,
  input  logic                 load_hi_i,
  input  rv32i_pkg::half_t     mem_rdata_i,
  output rv32i_pkg::xlen_t     rs1_data_o,
  output rv32i_pkg::xlen_t     rs2_data_o,
  output rv32i_pkg::reg_addr_t retire_rd_o,
  output rv32i_pkg::xlen_t     retire_wdata_o
);
  import rv32i_pkg::*;

  localparam int IDX_W = $clog2(NUM_REGS);

  xlen_t regs_q [NUM_REGS];
  xlen_t load_buf_q;
  xlen_t wb_value;
  logic  wr_en;

  // x0 and indices past the file are never written
  assign wr_en = reg_write_i && (rd_addr_i != '0) && (rd_addr_i < NUM_REGS);

  always_comb begin
    case (wb_sel_i)
      WB_LOAD: wb_value = load_buf_q;
      WB_LINK: wb_value = pc_i + 32'd4;
      WB_IMM:  wb_value = imm_i;
      default: wb_value = alu_result_i;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!microcode_reset) begin
      for (int i = 0; i < NUM_REGS; i++)
        regs_q[i] <= '0;
    end else if (wr_en) begin
      regs_q[rd_addr_i[IDX_W-1:0]] <= wb_value;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_lo_i) load_buf_q[15:0] <= mem_rdata_i;
    if (load_hi_i) load_buf_q[31:16] <= mem_rdata_i;
  end

  assign rs1_data_o = (rs1_addr_i == '0 || rs1_addr_i >= NUM_REGS) ? '0
                    : regs_q[rs1_addr_i[IDX_W-1:0]];
  assign rs2_data_o = (rs2_addr_i == '0 || rs2_addr_i >= NUM_REGS) ? '0
                    : regs_q[rs2_addr_i[IDX_W-1:0]];

  assign retire_rd_o    = wr_en ? rd_addr_i : '0;
  assign retire_wdata_o = wr_en ? wb_value : '0;

endmodule

/* rtl/rv32i_control.sv */
`timescale 1ns/1ns

module rv32i_control #(
  parameter rv32i_pkg::xlen_t RESET_PC = 32'h0000_0000
) (
  input  logic                   clk_i,
  input  logic                   microcode_reset,
  input  logic                   mem_ready_i,
  input  rv32i_pkg::inst_class_t inst_class_i,
  input  logic                   branch_taken_i,
  input  rv32i_pkg::xlen_t       alu_result_i,
  input  rv32i_pkg::xlen_t       rs2_data_i,
  output logic                   mem_valid_o,
  output logic                   mem_write_o,
  output rv32i_pkg::xlen_t       mem_addr_o,
  output rv32i_pkg::half_t       mem_wdata_o,
  output logic                   fetch_lo_o,
  output logic                   fetch_hi_o,
  output logic                   load_lo_o,
  output logic                   load_hi_o,
  output logic                   op_a_pc_o,
  output logic                   op_b_imm_o,
  output rv32i_pkg::alu_mode_t   alu_mode_o,
  output logic                   reg_write_o,
  output rv32i_pkg::wb_sel_t     wb_sel_o,
  output rv32i_pkg::xlen_t       pc_o,
  output logic                   retire_valid_o,
  output rv32i_pkg::xlen_t       retire_pc_o,
  output logic                   halt_o
);
  import rv32i_pkg::*;

  seq_state_t state_q;
  seq_state_t state_d;
  xlen_t      pc_q;
  xlen_t      ea_q;      // load/store address or jump target from EXEC
  logic       taken_q;
  logic       bus_en_q;  // low while in reset
  logic       handshake;
  logic       mem_step;
  logic       is_mem;
  logic       writes_rd;
  xlen_t      next_pc;

  assign handshake = mem_valid_o & mem_ready_i;
  assign mem_step  = (state_q == MEM_LO) || (state_q == MEM_HI);
  assign is_mem    = (inst_class_i == CLASS_LOAD) || (inst_class_i == CLASS_STORE);

  // microcode columns that depend on the class only
  always_comb begin
    op_a_pc_o  = 1'b0;
    op_b_imm_o = 1'b1;
    alu_mode_o = ALU_ADD;
    wb_sel_o   = WB_ALU;
    writes_rd  = 1'b1;
    case (inst_class_i)
      CLASS_LUI:   wb_sel_o = WB_IMM;
      CLASS_AUIPC: op_a_pc_o = 1'b1;
      CLASS_JAL: begin
        op_a_pc_o = 1'b1;  // target = pc + imm
        wb_sel_o  = WB_LINK;
      end
      CLASS_JALR:  wb_sel_o = WB_LINK;
      CLASS_BRANCH: begin
        op_a_pc_o = 1'b1;
        writes_rd = 1'b0;
      end
      CLASS_LOAD:  wb_sel_o = WB_LOAD;
      CLASS_STORE: writes_rd = 1'b0;
      CLASS_OPIMM: alu_mode_o = ALU_FUNCT_IMM;
      CLASS_OP: begin
        alu_mode_o = ALU_FUNCT_REG;
        op_b_imm_o = 1'b0;
      end
      default:     writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_LO: if (handshake) state_d = FETCH_HI;
      FETCH_HI: if (handshake) state_d = EXEC;
      EXEC: begin
        if (inst_class_i == CLASS_ILLEGAL) state_d = HALTED;
        else if (is_mem) state_d = MEM_LO;
        else state_d = WRITEBACK;
      end
      MEM_LO:    if (handshake) state_d = MEM_HI;
      MEM_HI:    if (handshake) state_d = WRITEBACK;
      WRITEBACK: state_d = FETCH_LO;
      default:   state_d = HALTED;  // held until reset
    endcase
  end

  always_comb begin
    next_pc = pc_q + 32'd4;
    if (inst_class_i == CLASS_JAL || (inst_class_i == CLASS_BRANCH && taken_q))
      next_pc = ea_q;
    else if (inst_class_i == CLASS_JALR)
      next_pc = {ea_q[31:1], 1'b0};
  end

  always_ff @(posedge clk_i) begin
    if (!microcode_reset) begin
      state_q  <= FETCH_LO;
      pc_q     <= RESET_PC;
      bus_en_q <= 1'b0;
    end else begin
      state_q  <= state_d;
      bus_en_q <= 1'b1;
      if (state_q == WRITEBACK) pc_q <= next_pc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == EXEC) begin
      ea_q    <= alu_result_i;
      taken_q <= branch_taken_i;
    end
  end

  assign mem_valid_o = bus_en_q & ((state_q == FETCH_LO) || (state_q == FETCH_HI) || mem_step);
  assign mem_write_o = mem_step & (inst_class_i == CLASS_STORE);
  assign mem_wdata_o = (state_q == MEM_HI) ? rs2_data_i[31:16] : rs2_data_i[15:0];

  always_comb begin
    case (state_q)
      FETCH_HI: mem_addr_o = pc_q + 32'd2;
      MEM_LO:   mem_addr_o = ea_q;
      MEM_HI:   mem_addr_o = ea_q + 32'd2;
      default:  mem_addr_o = pc_q;
    endcase
  end

  assign fetch_lo_o = handshake & (state_q == FETCH_LO);
  assign fetch_hi_o = handshake & (state_q == FETCH_HI);
  assign load_lo_o  = handshake & (state_q == MEM_LO) & (inst_class_i == CLASS_LOAD);
  assign load_hi_o  = handshake & (state_q == MEM_HI) & (inst_class_i == CLASS_LOAD);

  assign reg_write_o    = (state_q == WRITEBACK) & writes_rd;
  assign retire_valid_o = (state_q == WRITEBACK);
  assign retire_pc_o    = pc_q;
  assign pc_o           = pc_q;
  assign halt_o         = (state_q == HALTED);

endmodule

/* rtl/rv32i_core.sv */
`timescale 1ns/1ns

module rv32i_core #(
  parameter rv32i_pkg::xlen_t RESET_PC = 32'h0000_0000,
  parameter int               NUM_REGS = 32
) (
  input  logic                 clk_i,
  input  logic                 microcode_reset,
  output logic                 mem_valid_o,
  output logic                 mem_write_o,
  output rv32i_pkg::xlen_t     mem_addr_o,
  output rv32i_pkg::half_t     mem_wdata_o,
  input  logic                 mem_ready_i,
  input  rv32i_pkg::half_t     mem_rdata_i,
  output logic                 retire_valid_o,
  output rv32i_pkg::xlen_t     retire_pc_o,
  output rv32i_pkg::reg_addr_t retire_rd_o,
  output rv32i_pkg::xlen_t     retire_wdata_o,
  output logic                 halt_o
);
  import rv32i_pkg::*;

  inst_class_t inst_class;
  reg_addr_t   rs1_addr;
  reg_addr_t   rs2_addr;
  reg_addr_t   rd_addr;
  logic [2:0]  funct3;
  logic        funct7_b5;
  xlen_t       imm;
  logic        fetch_lo;
  logic        fetch_hi;
  logic        load_lo;
  logic        load_hi;
  logic        op_a_pc;
  logic        op_b_imm;
  alu_mode_t   alu_mode;
  xlen_t       alu_result;
  logic        branch_taken;
  xlen_t       rs1_data;
  xlen_t       rs2_data;
  logic        reg_write;
  wb_sel_t     wb_sel;
  xlen_t       pc;

  rv32i_control #(
    .RESET_PC(RESET_PC)
  ) u_control (
    .clk_i          (clk_i),
    .microcode_reset(microcode_reset),
    .mem_ready_i    (mem_ready_i),
    .inst_class_i   (inst_class),
    .branch_taken_i (branch_taken),
    .alu_result_i   (alu_result),
    .rs2_data_i     (rs2_data),
    .mem_valid_o    (mem_valid_o),
    .mem_write_o    (mem_write_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .fetch_lo_o     (fetch_lo),
    .fetch_hi_o     (fetch_hi),
    .load_lo_o      (load_lo),
    .load_hi_o      (load_hi),
    .op_a_pc_o      (op_a_pc),
    .op_b_imm_o     (op_b_imm),
    .alu_mode_o     (alu_mode),
    .reg_write_o    (reg_write),
    .wb_sel_o       (wb_sel),
    .pc_o           (pc),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .halt_o         (halt_o)
  );

  rv32i_decode u_decode (
    .clk_i          (clk_i),
    .microcode_reset(microcode_reset),
    .load_lo_i      (fetch_lo),
    .load_hi_i      (fetch_hi),
    .fetch_half_i   (mem_rdata_i),
    .inst_class_o   (inst_class),
    .rs1_addr_o     (rs1_addr),
    .rs2_addr_o     (rs2_addr),
    .rd_addr_o      (rd_addr),
    .funct3_o       (funct3),
    .funct7_b5_o    (funct7_b5),
    .imm_o          (imm)
  );

  rv32i_execute u_execute (
    .pc_i          (pc),
    .rs1_data_i    (rs1_data),
    .rs2_data_i    (rs2_data),
    .imm_i         (imm),
    .op_a_pc_i     (op_a_pc),
    .op_b_imm_i    (op_b_imm),
    .alu_mode_i    (alu_mode),
    .funct3_i      (funct3),
    .funct7_b5_i   (funct7_b5),
    .alu_result_o  (alu_result),
    .branch_taken_o(branch_taken)
  );

  rv32i_result #(
    .NUM_REGS(NUM_REGS)
  ) u_result (
    .clk_i          (clk_i),
    .microcode_reset(microcode_reset),
    .rs1_addr_i     (rs1_addr),
    .rs2_addr_i     (rs2_addr),
    .rd_addr_i      (rd_addr),
    .reg_write_i    (reg_write),
    .wb_sel_i       (wb_sel),
    .alu_result_i   (alu_result),
    .imm_i          (imm),
    .pc_i           (pc),
    .load_lo_i      (load_lo),
    .load_hi_i      (load_hi),
    .mem_rdata_i    (mem_rdata_i),
    .rs1_data_o     (rs1_data),
    .rs2_data_o     (rs2_data),
    .retire_rd_o    (retire_rd_o),
    .retire_wdata_o (retire_wdata_o)
  );

endmodule

/* verification/rv32i_core_assertions.sv */
`timescale 1ns/1ns

module rv32i_core_assertions (
  input logic             clk_i,
  input logic             microcode_reset,
  input logic             valid_i,
  input logic             write_i,
  input rv32i_pkg::xlen_t addr_i,
  input rv32i_pkg::half_t wdata_i,
  input logic             ready_i,
  input logic             retire_i,
  input logic             halt_i
);
  int unsigned fail_count = 0;

  // a stalled beat keeps every bus output
  stall_holds: assert property (@(posedge clk_i) disable iff (!microcode_reset)
    valid_i && !ready_i |=> valid_i && $stable(write_i) && $stable(addr_i) && $stable(wdata_i))
    else begin $error("bus outputs changed during a stall"); fail_count++; end

  quiet_in_reset: assert property (@(posedge clk_i)
    !microcode_reset |=> !valid_i && !retire_i && !halt_i)
    else begin $error("bus, retire or halt active in reset"); fail_count++; end

  halt_sticky: assert property (@(posedge clk_i) disable iff (!microcode_reset)
    halt_i |=> halt_i && !valid_i && !retire_i)
    else begin $error("activity after halt"); fail_count++; end

  retire_pulse: assert property (@(posedge clk_i) disable iff (!microcode_reset)
    retire_i |=> !retire_i)
    else begin $error("retire held longer than one cycle"); fail_count++; end

endmodule

bind rv32i_core rv32i_core_assertions u_assertions (
  .clk_i          (clk_i),
  .microcode_reset(microcode_reset),
  .valid_i        (mem_valid_o),
  .write_i        (mem_write_o),
  .addr_i         (mem_addr_o),
  .wdata_i        (mem_wdata_o),
  .ready_i        (mem_ready_i),
  .retire_i       (retire_valid_o),
  .halt_i         (halt_o)
);

/* verification/rv32i_core_tb.sv */
`timescale 1ns/1ns

module rv32i_core_tb;
  import rv32i_pkg::*;

  localparam int          CLK_PERIOD = 8;
  localparam int          PROG_LEN   = 160;  // ecall sits at this slot
  localparam int          MAX_STALL  = 3;
  localparam int          MEM_HALVES = 8192;
  localparam int unsigned SEED       = 32'h8ee8a79f;
  localparam int          TIMEOUT_NS = (PROG_LEN + 1) * 6 * (MAX_STALL + 1) * CLK_PERIOD + 2000;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam xlen_t      ECALL      = 32'h0000_0073;

  logic      clk_i;
  logic      microcode_reset;
  logic      mem_valid_o;
  logic      mem_write_o;
  xlen_t     mem_addr_o;
  half_t     mem_wdata_o;
  logic      mem_ready_i;
  half_t     mem_rdata_i;
  logic      retire_valid_o;
  xlen_t     retire_pc_o;
  reg_addr_t retire_rd_o;
  xlen_t     retire_wdata_o;
  logic      halt_o;

  half_t       mem [MEM_HALVES];      // model memory seen by the DUT
  half_t       ref_mem [MEM_HALVES];  // reference copy
  xlen_t       ref_regs [32];
  xlen_t       ref_pc;
  xlen_t       exp_npc;
  reg_addr_t   exp_rd;
  xlen_t       exp_wdata;
  logic        exp_stop;
  int unsigned stall_cnt;
  int unsigned retired;
  int unsigned seed_val;

  rv32i_core #(
    .RESET_PC(32'h0000_0000),
    .NUM_REGS(32)
  ) dut (
    .clk_i          (clk_i),
    .microcode_reset(microcode_reset),
    .mem_valid_o    (mem_valid_o),
    .mem_write_o    (mem_write_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .mem_ready_i    (mem_ready_i),
    .mem_rdata_i    (mem_rdata_i),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_wdata_o (retire_wdata_o),
    .halt_o         (halt_o)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("[FAIL] %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp));
  endtask

  function automatic xlen_t branch_word(logic [12:0] off, reg_addr_t rs2, reg_addr_t rs1,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic xlen_t jal_word(logic [20:0] off, reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  function automatic xlen_t store_word(logic [11:0] off, reg_addr_t rs2, reg_addr_t rs1);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], OPC_STORE};
  endfunction

  // x1 holds the data base, so it is never a destination
  function automatic reg_addr_t pick_rd();
    if ($urandom_range(0, 7) == 0) return 5'd0;
    return reg_addr_t'($urandom_range(2, 31));
  endfunction

  task automatic place_inst(input int slot, input xlen_t word);
    mem[slot * 2]     = word[15:0];
    mem[slot * 2 + 1] = word[31:16];
  endtask

  task automatic build_program();
    int unsigned kind;
    int unsigned k;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    logic [2:0]  f3;
    logic [11:0] imm12;
    logic        alt;
    xlen_t       word;
    for (int i = 0; i < MEM_HALVES; i++)
      mem[i] = half_t'(i ^ (i << 7) ^ 16'h5a3c);
    place_inst(0, {20'h00001, 5'd1, OPC_LUI});  // data region at 0x1000
    for (int r = 2; r < 16; r++)
      place_inst(r - 1, {20'($urandom), reg_addr_t'(r), OPC_LUI});
    // x0 against x1 and x0 against x0 give every condition both outcomes
    for (int c = 0; c < 12; c++) begin
      f3 = 3'(c / 2);
      if (f3 >= 3'd2) f3 = f3 + 3'd2;
      rs2 = (c % 2 == 0) ? 5'd1 : 5'd0;
      place_inst(15 + 2 * c, branch_word(13'd8, rs2, 5'd0, f3));
      place_inst(16 + 2 * c, {12'd0, 5'd0, 3'b000, 5'd0, OPC_OPIMM});  // nop, skipped if taken
    end
    for (int i = 39; i < PROG_LEN; i++) begin
      kind  = $urandom_range(0, 15);
      rd    = pick_rd();
      rs1   = reg_addr_t'($urandom);
      rs2   = ($urandom_range(0, 2) == 0) ? rs1 : reg_addr_t'($urandom);
      f3    = 3'($urandom);
      imm12 = 12'($urandom);
      k     = $urandom_range(2, 3);
      if (i + k > PROG_LEN) k = PROG_LEN - i;  // forward only, never past the ecall
      case (kind)
        0, 1, 2, 3, 4: begin
          alt  = imm12[0] && (f3 == 3'b000 || f3 == 3'b101);
          word = {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OPC_OP};
        end
        5, 6, 7, 15: begin
          if (f3 == 3'b001) imm12 = {7'b0, imm12[4:0]};
          if (f3 == 3'b101) imm12 = {1'b0, imm12[11], 5'b0, imm12[4:0]};
          word = {imm12, rs1, f3, rd, OPC_OPIMM};
        end
        8:  word = {20'($urandom), rd, OPC_LUI};
        9:  word = {20'($urandom), rd, OPC_AUIPC};
        10: begin
          f3 = 3'($urandom_range(0, 5));
          if (f3 >= 3'd2) f3 = f3 + 3'd2;
          word = branch_word(13'(k * 4), rs2, rs1, f3);
        end
        11: word = jal_word(21'(k * 4), rd);
        12: word = {12'((i + k) * 4 + imm12[0]), 5'd0, 3'b000, rd, OPC_JALR};  // odd target
        13: word = {6'b0, imm12[3:0], 2'b00, 5'd1, 3'b010, rd, OPC_LOAD};
        default: word = store_word({6'b0, imm12[3:0], 2'b00}, rs2, 5'd1);
      endcase
      place_inst(i, word);
    end
    place_inst(PROG_LEN, ECALL);
  endtask

  function automatic xlen_t alu_op(logic [2:0] f3, logic alt, xlen_t a, xlen_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b011:  return (a < b) ? 32'd1 : 32'd0;
      3'b100:  return a ^ b;
      3'b101:  return alt ? xlen_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  // executes one instruction on the reference state
  function automatic void predict_retire(input xlen_t pc, output xlen_t npc,
                                         output reg_addr_t rd_exp, output xlen_t wd_exp,
                                         output logic stop);
    xlen_t      inst;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    xlen_t      addr;
    xlen_t      imm_i;
    logic [2:0] f3;
    logic       wr;
    logic       taken;
    inst  = {ref_mem[pc[13:1] + 1], ref_mem[pc[13:1]]};
    f3    = inst[14:12];
    a     = ref_regs[inst[19:15]];
    b     = ref_regs[inst[24:20]];
    imm_i = {{20{inst[31]}}, inst[31:20]};
    npc   = pc + 32'd4;
    res   = '0;
    wr    = 1'b0;
    stop  = 1'b0;
    case (inst[6:0])
      OPC_LUI: begin
        res = {inst[31:12], 12'b0};
        wr  = 1'b1;
      end
      OPC_AUIPC: begin
        res = pc + {inst[31:12], 12'b0};
        wr  = 1'b1;
      end
      OPC_JAL: begin
        res = pc + 32'd4;
        wr  = 1'b1;
        npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      OPC_JALR: begin
        res = pc + 32'd4;
        wr  = 1'b1;
        npc = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000:  taken = (a == b);
          3'b001:  taken = (a != b);
          3'b100:  taken = ($signed(a) < $signed(b));
          3'b101:  taken = ($signed(a) >= $signed(b));
          3'b110:  taken = (a < b);
          default: taken = (a >= b);
        endcase
        if (taken) npc = pc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        res  = {ref_mem[addr[13:1] + 1], ref_mem[addr[13:1]]};
        wr   = 1'b1;
      end
      OPC_STORE: begin
        addr = a + {{20{inst[31]}}, inst[31:25], inst[11:7]};
        ref_mem[addr[13:1]]     = b[15:0];  // low half at A, high half at A+2
        ref_mem[addr[13:1] + 1] = b[31:16];
      end
      OPC_OPIMM: begin
        res = alu_op(f3, f3 == 3'b101 && inst[30], a, imm_i);
        wr  = 1'b1;
      end
      OPC_OP: begin
        res = alu_op(f3, inst[30], a, b);
        wr  = 1'b1;
      end
      default: stop = 1'b1;
    endcase
    rd_exp = '0;
    wd_exp = '0;
    if (wr && inst[11:7] != 5'd0) begin
      ref_regs[inst[11:7]] = res;
      rd_exp = inst[11:7];
      wd_exp = res;
    end
  endfunction

  // memory model with bounded random back-pressure
  always @(posedge clk_i) begin
    if (mem_valid_o && mem_ready_i) begin
      if (mem_write_o) mem[mem_addr_o[13:1]] = mem_wdata_o;
      stall_cnt = 0;
    end else if (mem_valid_o) begin
      stall_cnt++;
    end
    #1;
    mem_ready_i = (stall_cnt >= MAX_STALL) ? 1'b1 : 1'($urandom_range(0, 1));
    mem_rdata_i = mem[mem_addr_o[13:1]];
  end

  always @(posedge clk_i) begin
    if (microcode_reset && retire_valid_o) begin
      predict_retire(ref_pc, exp_npc, exp_rd, exp_wdata, exp_stop);
      if (exp_stop)
        abort_run($sformatf("DUT retired the halting instruction at pc %h", ref_pc));
      check_word(retire_pc_o, ref_pc, "retire_pc");
      check_reg(retire_rd_o, exp_rd, "retire_rd");
      if (exp_rd != 5'd0) check_word(retire_wdata_o, exp_wdata, "retire_wdata");
      ref_pc = exp_npc;
      retired++;
    end
  end

  always @(posedge clk_i) begin
    if (dut.u_assertions.fail_count != 0)
      abort_run("a bus, reset or halt assertion failed during the run");
  end

  initial begin
    #(TIMEOUT_NS);
    abort_run("timeout: the core did not halt within the allowed time");
  end

  initial begin
    seed_val        = $urandom(SEED);
    microcode_reset = 1'b0;
    mem_ready_i     = 1'b0;
    mem_rdata_i     = '0;
    stall_cnt       = 0;
    retired         = 0;
    build_program();
    for (int i = 0; i < MEM_HALVES; i++)
      ref_mem[i] = mem[i];
    for (int r = 0; r < 32; r++)
      ref_regs[r] = '0;
    ref_pc = 32'h0000_0000;
    repeat (8) @(posedge clk_i);
    #1 microcode_reset = 1'b1;
    wait (halt_o === 1'b1);
    check_word({ref_mem[ref_pc[13:1] + 1], ref_mem[ref_pc[13:1]]}, ECALL, "instruction at halt");
    repeat (16) begin
      @(posedge clk_i);
      if (retire_valid_o || mem_valid_o || !halt_o)
        abort_run("core left the halted state or touched the bus after halting");
    end
    for (int w = 0; w < MEM_HALVES / 2; w++)
      check_word({mem[2 * w + 1], mem[2 * w]}, {ref_mem[2 * w + 1], ref_mem[2 * w]},
                 $sformatf("memory word at %h", w * 4));
    $display("retired %0d instructions", retired);
    if (dut.u_assertions.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run($sformatf("%0d bus or halt assertions failed", dut.u_assertions.fail_count));
    end
  end

endmodule

/* flist.f */
rtl/rv32i_pkg.sv
rtl/rv32i_decode.sv
rtl/rv32i_execute.sv
rtl/rv32i_result.sv
rtl/rv32i_control.sv
rtl/rv32i_core.sv
verification/rv32i_core_assertions.sv
verification/rv32i_core_tb.sv
